/* verilog/mc_ctrl_cfg.svh */
`ifndef MC_CTRL_CFG_SVH
`define MC_CTRL_CFG_SVH

// instruction register fields
`define MC_OPCODE_W 6
`define MC_FUNCT_W 6

// sequencer encodings
`define MC_STATE_W 5
`define MC_INSTR_W 5

// datapath control fields
`define MC_ALU_OP_W 3
`define MC_SH_OP_W 3
`define MC_WB_SRC_W 3

// the two-bit mux selects
`define MC_SEL_W 2

`endif

/* verilog/mc_ctrl_pkg.sv */
`include "mc_ctrl_cfg.svh"

package mc_ctrl_pkg;

    typedef enum logic [`MC_OPCODE_W-1:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_LUI   = 6'h0f,
        OP_LB    = 6'h20,
        OP_LW    = 6'h23,
        OP_SB    = 6'h28,
        OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [`MC_FUNCT_W-1:0] {
        FN_SLL = 6'h00,
        FN_SRA = 6'h03,
        FN_JR  = 6'h08,
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_SLT = 6'h2a
    } funct_e;

    typedef enum logic [`MC_INSTR_W-1:0] {
        I_NONE, I_ADD, I_AND, I_SUB, I_SLT, I_SLL, I_SRA, I_JR, I_J,
        I_ADDI, I_BEQ, I_BNE, I_LUI, I_LW, I_SW, I_LB, I_SB
    } instr_e;

    typedef enum logic [`MC_STATE_W-1:0] {
        ST_RESET, ST_FETCH, ST_TARGET, ST_DECODE,
        ST_ALU_EXEC, ST_ALU_WB, ST_SHIFT_EXEC, ST_SHIFT_WB, ST_SLT,
        ST_JUMP, ST_JUMP_REG, ST_IMM_EXEC, ST_IMM_WB, ST_BRANCH, ST_LUI_WB,
        ST_ADDR_CALC, ST_LOAD_READ, ST_LOAD_WB, ST_STORE_WORD,
        ST_BYTE_READ, ST_BYTE_STORE
    } ctrl_state_e;

    typedef enum logic [`MC_ALU_OP_W-1:0] {
        ALU_PASS = 3'b000,
        ALU_ADD  = 3'b001,
        ALU_SUB  = 3'b010,
        ALU_AND  = 3'b011
    } alu_op_e;

    typedef enum logic [`MC_SH_OP_W-1:0] {
        SH_NONE = 3'b000,
        SH_SLL  = 3'b010,
        SH_SRA  = 3'b100
    } sh_op_e;

    typedef enum logic [`MC_WB_SRC_W-1:0] {
        WB_SHIFT = 3'b000,
        WB_WORD  = 3'b010,
        WB_SLT   = 3'b011,
        WB_BYTE  = 3'b100,
        WB_ALU   = 3'b101,
        WB_UPPER = 3'b110
    } wb_src_e;

    typedef enum logic [`MC_SEL_W-1:0] {PC_ALU, PC_TARGET, PC_JUMP, PC_REG} pc_src_e;
    typedef enum logic [`MC_SEL_W-1:0] {SRC_A_PC, SRC_A_REG} alu_src_a_e;
    typedef enum logic [`MC_SEL_W-1:0] {
        SRC_B_REG, SRC_B_FOUR, SRC_B_IMM, SRC_B_IMM_SHIFTED
    } alu_src_b_e;
    typedef enum logic [`MC_SEL_W-1:0] {DST_RT, DST_RD} reg_dst_e;

endpackage

/* verilog/ctrl_word_if.sv */
`timescale 1ns/100ps

interface ctrl_word_if;

    logic pc_write;
    logic mem_read;
    logic mem_write;
    logic byte_or_word; // 1 = byte store
    logic addr_from_alu; // 0 = pc, 1 = alu result
    logic ir_write;
    logic reg_write;

    mc_ctrl_pkg::alu_op_e    alu_op;
    mc_ctrl_pkg::alu_src_a_e alu_src_a;
    mc_ctrl_pkg::alu_src_b_e alu_src_b;
    mc_ctrl_pkg::sh_op_e     sh_op;
    mc_ctrl_pkg::wb_src_e    wb_src;
    mc_ctrl_pkg::pc_src_e    pc_src;
    mc_ctrl_pkg::reg_dst_e   reg_dst;

    modport gen (
        output pc_write, mem_read, mem_write, byte_or_word, addr_from_alu,
        output ir_write, reg_write, alu_op, alu_src_a, alu_src_b, sh_op,
        output wb_src, pc_src, reg_dst
    );

    modport sink (
        input pc_write, mem_read, mem_write, byte_or_word, addr_from_alu,
        input ir_write, reg_write, alu_op, alu_src_a, alu_src_b, sh_op,
        input wb_src, pc_src, reg_dst
    );

endinterface

/* verilog/instr_decoder.sv */
`timescale 1ns/100ps

module instr_decoder (
    input  mc_ctrl_pkg::opcode_e i_opcode,
    input  mc_ctrl_pkg::funct_e  i_funct,
    output mc_ctrl_pkg::instr_e  o_instr
);

    always_comb begin
        o_instr = mc_ctrl_pkg::I_NONE; // unlisted codes fall back to fetch
        case (i_opcode)
            mc_ctrl_pkg::OP_RTYPE: begin
                case (i_funct)
                    mc_ctrl_pkg::FN_ADD: o_instr = mc_ctrl_pkg::I_ADD;
                    mc_ctrl_pkg::FN_AND: o_instr = mc_ctrl_pkg::I_AND;
                    mc_ctrl_pkg::FN_SUB: o_instr = mc_ctrl_pkg::I_SUB;
                    mc_ctrl_pkg::FN_SLT: o_instr = mc_ctrl_pkg::I_SLT;
                    mc_ctrl_pkg::FN_SLL: o_instr = mc_ctrl_pkg::I_SLL;
                    mc_ctrl_pkg::FN_SRA: o_instr = mc_ctrl_pkg::I_SRA;
                    mc_ctrl_pkg::FN_JR:  o_instr = mc_ctrl_pkg::I_JR;
                    default:             o_instr = mc_ctrl_pkg::I_NONE;
                endcase
            end
            mc_ctrl_pkg::OP_J:    o_instr = mc_ctrl_pkg::I_J;
            mc_ctrl_pkg::OP_ADDI: o_instr = mc_ctrl_pkg::I_ADDI;
            mc_ctrl_pkg::OP_BEQ:  o_instr = mc_ctrl_pkg::I_BEQ;
            mc_ctrl_pkg::OP_BNE:  o_instr = mc_ctrl_pkg::I_BNE;
            mc_ctrl_pkg::OP_LUI:  o_instr = mc_ctrl_pkg::I_LUI;
            mc_ctrl_pkg::OP_LW:   o_instr = mc_ctrl_pkg::I_LW;
            mc_ctrl_pkg::OP_SW:   o_instr = mc_ctrl_pkg::I_SW;
            mc_ctrl_pkg::OP_LB:   o_instr = mc_ctrl_pkg::I_LB;
            mc_ctrl_pkg::OP_SB:   o_instr = mc_ctrl_pkg::I_SB;
            default:              o_instr = mc_ctrl_pkg::I_NONE;
        endcase
    end

endmodule

/* verilog/ctrl_sequencer.sv */
`timescale 1ns/100ps

module ctrl_sequencer (
    input  logic                     clk,
    input  logic                     reset,
    input  mc_ctrl_pkg::instr_e      i_instr,
    output mc_ctrl_pkg::ctrl_state_e o_state,
    output mc_ctrl_pkg::instr_e      o_instr
);

    mc_ctrl_pkg::ctrl_state_e state_q;
    mc_ctrl_pkg::ctrl_state_e state_nxt;
    mc_ctrl_pkg::instr_e      instr_q;

    always_comb begin
        state_nxt = mc_ctrl_pkg::ST_FETCH; // every path ends back in fetch
        case (state_q)
            mc_ctrl_pkg::ST_FETCH:  state_nxt = mc_ctrl_pkg::ST_TARGET;
            mc_ctrl_pkg::ST_TARGET: state_nxt = mc_ctrl_pkg::ST_DECODE;
            mc_ctrl_pkg::ST_DECODE: begin
                case (i_instr)
                    mc_ctrl_pkg::I_ADD,
                    mc_ctrl_pkg::I_AND,
                    mc_ctrl_pkg::I_SUB:  state_nxt = mc_ctrl_pkg::ST_ALU_EXEC;
                    mc_ctrl_pkg::I_SLL,
                    mc_ctrl_pkg::I_SRA:  state_nxt = mc_ctrl_pkg::ST_SHIFT_EXEC;
                    mc_ctrl_pkg::I_SLT:  state_nxt = mc_ctrl_pkg::ST_SLT;
                    mc_ctrl_pkg::I_JR:   state_nxt = mc_ctrl_pkg::ST_JUMP_REG;
                    mc_ctrl_pkg::I_J:    state_nxt = mc_ctrl_pkg::ST_JUMP;
                    mc_ctrl_pkg::I_ADDI: state_nxt = mc_ctrl_pkg::ST_IMM_EXEC;
                    mc_ctrl_pkg::I_BEQ,
                    mc_ctrl_pkg::I_BNE:  state_nxt = mc_ctrl_pkg::ST_BRANCH;
                    mc_ctrl_pkg::I_LUI:  state_nxt = mc_ctrl_pkg::ST_LUI_WB;
                    mc_ctrl_pkg::I_LW,
                    mc_ctrl_pkg::I_LB,
                    mc_ctrl_pkg::I_SW,
                    mc_ctrl_pkg::I_SB:   state_nxt = mc_ctrl_pkg::ST_ADDR_CALC;
                    default:             state_nxt = mc_ctrl_pkg::ST_FETCH;
                endcase
            end
            mc_ctrl_pkg::ST_ALU_EXEC:   state_nxt = mc_ctrl_pkg::ST_ALU_WB;
            mc_ctrl_pkg::ST_SHIFT_EXEC: state_nxt = mc_ctrl_pkg::ST_SHIFT_WB;
            mc_ctrl_pkg::ST_IMM_EXEC:   state_nxt = mc_ctrl_pkg::ST_IMM_WB;
            mc_ctrl_pkg::ST_ADDR_CALC: begin
                case (instr_q) // memory paths split on the latched kind
                    mc_ctrl_pkg::I_SW: state_nxt = mc_ctrl_pkg::ST_STORE_WORD;
                    mc_ctrl_pkg::I_SB: state_nxt = mc_ctrl_pkg::ST_BYTE_READ;
                    default:           state_nxt = mc_ctrl_pkg::ST_LOAD_READ;
                endcase
            end
            mc_ctrl_pkg::ST_LOAD_READ: state_nxt = mc_ctrl_pkg::ST_LOAD_WB;
            mc_ctrl_pkg::ST_BYTE_READ: state_nxt = mc_ctrl_pkg::ST_BYTE_STORE;
            default:                   state_nxt = mc_ctrl_pkg::ST_FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= mc_ctrl_pkg::ST_RESET;
            instr_q <= mc_ctrl_pkg::I_NONE;
        end else begin
            state_q <= state_nxt;
            if (state_q == mc_ctrl_pkg::ST_DECODE) begin
                instr_q <= i_instr; // held until the next decode
            end
        end
    end

    assign o_state = state_q;
    assign o_instr = instr_q;

endmodule

/* verilog/ctrl_word_gen.sv */
`timescale 1ns/100ps

module ctrl_word_gen (
    input  mc_ctrl_pkg::ctrl_state_e i_state,
    input  mc_ctrl_pkg::instr_e      i_instr,
    input  logic                     i_eq,
    ctrl_word_if.gen                 ctrl
);

    always_comb begin
        ctrl.pc_write      = 1'b0;
        ctrl.mem_read      = 1'b0;
        ctrl.mem_write     = 1'b0;
        ctrl.byte_or_word  = 1'b0;
        ctrl.addr_from_alu = 1'b0;
        ctrl.ir_write      = 1'b0;
        ctrl.reg_write     = 1'b0;
        ctrl.alu_op        = mc_ctrl_pkg::ALU_PASS;
        ctrl.alu_src_a     = mc_ctrl_pkg::SRC_A_PC;
        ctrl.alu_src_b     = mc_ctrl_pkg::SRC_B_REG;
        ctrl.sh_op         = mc_ctrl_pkg::SH_NONE;
        ctrl.wb_src        = mc_ctrl_pkg::WB_ALU;
        ctrl.pc_src        = mc_ctrl_pkg::PC_ALU;
        ctrl.reg_dst       = mc_ctrl_pkg::DST_RT;

        case (i_state)
            mc_ctrl_pkg::ST_FETCH: begin
                ctrl.mem_read  = 1'b1;
                ctrl.ir_write  = 1'b1;
                ctrl.pc_write  = 1'b1; // pc + 4
                ctrl.alu_op    = mc_ctrl_pkg::ALU_ADD;
                ctrl.alu_src_b = mc_ctrl_pkg::SRC_B_FOUR;
            end
            mc_ctrl_pkg::ST_TARGET: begin
                ctrl.alu_op    = mc_ctrl_pkg::ALU_ADD; // branch target into aluout
                ctrl.alu_src_b = mc_ctrl_pkg::SRC_B_IMM_SHIFTED;
            end
            mc_ctrl_pkg::ST_ALU_EXEC: begin
                case (i_instr)
                    mc_ctrl_pkg::I_AND: ctrl.alu_op = mc_ctrl_pkg::ALU_AND;
                    mc_ctrl_pkg::I_SUB: ctrl.alu_op = mc_ctrl_pkg::ALU_SUB;
                    default:            ctrl.alu_op = mc_ctrl_pkg::ALU_ADD;
                endcase
                ctrl.alu_src_a = mc_ctrl_pkg::SRC_A_REG;
            end
            mc_ctrl_pkg::ST_SHIFT_EXEC: begin
                ctrl.sh_op = (i_instr == mc_ctrl_pkg::I_SRA) ? mc_ctrl_pkg::SH_SRA
                                                            : mc_ctrl_pkg::SH_SLL;
            end
            mc_ctrl_pkg::ST_ALU_WB, mc_ctrl_pkg::ST_SHIFT_WB, mc_ctrl_pkg::ST_SLT: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = mc_ctrl_pkg::DST_RD;
                if (i_state == mc_ctrl_pkg::ST_SHIFT_WB) begin
                    ctrl.wb_src = mc_ctrl_pkg::WB_SHIFT;
                end else if (i_state == mc_ctrl_pkg::ST_SLT) begin
                    ctrl.wb_src    = mc_ctrl_pkg::WB_SLT; // sign of a - b
                    ctrl.alu_op    = mc_ctrl_pkg::ALU_SUB;
                    ctrl.alu_src_a = mc_ctrl_pkg::SRC_A_REG;
                end
            end
            mc_ctrl_pkg::ST_BRANCH: begin
                ctrl.alu_op    = mc_ctrl_pkg::ALU_SUB;
                ctrl.alu_src_a = mc_ctrl_pkg::SRC_A_REG;
                ctrl.pc_src    = mc_ctrl_pkg::PC_TARGET;
                ctrl.pc_write  = (i_instr == mc_ctrl_pkg::I_BNE) ? ~i_eq : i_eq;
            end
            mc_ctrl_pkg::ST_JUMP: begin
                ctrl.pc_write = 1'b1;
                ctrl.pc_src   = mc_ctrl_pkg::PC_JUMP;
            end
            mc_ctrl_pkg::ST_JUMP_REG: begin
                ctrl.pc_write = 1'b1;
                ctrl.pc_src   = mc_ctrl_pkg::PC_REG;
            end
            mc_ctrl_pkg::ST_IMM_EXEC, mc_ctrl_pkg::ST_ADDR_CALC: begin
                ctrl.alu_op    = mc_ctrl_pkg::ALU_ADD; // rs + imm
                ctrl.alu_src_a = mc_ctrl_pkg::SRC_A_REG;
                ctrl.alu_src_b = mc_ctrl_pkg::SRC_B_IMM;
            end
            mc_ctrl_pkg::ST_IMM_WB: begin
                ctrl.reg_write = 1'b1;
            end
            mc_ctrl_pkg::ST_LUI_WB: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_src    = mc_ctrl_pkg::WB_UPPER;
            end
            mc_ctrl_pkg::ST_LOAD_READ, mc_ctrl_pkg::ST_BYTE_READ: begin
                ctrl.mem_read      = 1'b1;
                ctrl.addr_from_alu = 1'b1;
            end
            mc_ctrl_pkg::ST_LOAD_WB: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_src    = (i_instr == mc_ctrl_pkg::I_LB) ? mc_ctrl_pkg::WB_BYTE
                                                               : mc_ctrl_pkg::WB_WORD;
            end
            mc_ctrl_pkg::ST_STORE_WORD, mc_ctrl_pkg::ST_BYTE_STORE: begin
                ctrl.mem_write     = 1'b1;
                ctrl.addr_from_alu = 1'b1;
                ctrl.byte_or_word  = (i_state == mc_ctrl_pkg::ST_BYTE_STORE);
            end
            default: ; // reset and decode keep the idle word
        endcase
    end

endmodule

/* verilog/mc_control_unit.sv */
`timescale 1ns/100ps

module mc_control_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  mc_ctrl_pkg::opcode_e     i_opcode,
    input  mc_ctrl_pkg::funct_e      i_funct,
    input  logic                     i_eq,
    output mc_ctrl_pkg::ctrl_state_e o_state,
    output logic                     o_pc_write,
    output logic                     o_mem_read,
    output logic                     o_mem_write,
    output logic                     o_byte_or_word,
    output logic                     o_addr_from_alu,
    output logic                     o_ir_write,
    output logic                     o_reg_write,
    output mc_ctrl_pkg::alu_op_e     o_alu_op,
    output mc_ctrl_pkg::alu_src_a_e  o_alu_src_a,
    output mc_ctrl_pkg::alu_src_b_e  o_alu_src_b,
    output mc_ctrl_pkg::sh_op_e      o_sh_op,
    output mc_ctrl_pkg::wb_src_e     o_wb_src,
    output mc_ctrl_pkg::pc_src_e     o_pc_src,
    output mc_ctrl_pkg::reg_dst_e    o_reg_dst
);

    mc_ctrl_pkg::instr_e dec_instr; // straight from the decoder
    mc_ctrl_pkg::instr_e lat_instr; // latched in decode

    ctrl_word_if ctrl_word_if_i ();

    instr_decoder instr_decoder_i (
        .i_opcode (i_opcode),
        .i_funct  (i_funct),
        .o_instr  (dec_instr)
    );

    ctrl_sequencer ctrl_sequencer_i (
        .clk     (clk),
        .reset   (reset),
        .i_instr (dec_instr),
        .o_state (o_state),
        .o_instr (lat_instr)
    );

    ctrl_word_gen ctrl_word_gen_i (
        .i_state (o_state),
        .i_instr (lat_instr),
        .i_eq    (i_eq),
        .ctrl    (ctrl_word_if_i.gen)
    );

    assign o_pc_write      = ctrl_word_if_i.pc_write;
    assign o_mem_read      = ctrl_word_if_i.mem_read;
    assign o_mem_write     = ctrl_word_if_i.mem_write;
    assign o_byte_or_word  = ctrl_word_if_i.byte_or_word;
    assign o_addr_from_alu = ctrl_word_if_i.addr_from_alu;
    assign o_ir_write      = ctrl_word_if_i.ir_write;
    assign o_reg_write     = ctrl_word_if_i.reg_write;
    assign o_alu_op        = ctrl_word_if_i.alu_op;
    assign o_alu_src_a     = ctrl_word_if_i.alu_src_a;
    assign o_alu_src_b     = ctrl_word_if_i.alu_src_b;
    assign o_sh_op         = ctrl_word_if_i.sh_op;
    assign o_wb_src        = ctrl_word_if_i.wb_src;
    assign o_pc_src        = ctrl_word_if_i.pc_src;
    assign o_reg_dst       = ctrl_word_if_i.reg_dst;

endmodule

/* tb/mc_control_unit_assert.sv */
`timescale 1ns/100ps

module mc_control_unit_assert (
    input logic                     clk,
    input logic                     reset,
    input mc_ctrl_pkg::ctrl_state_e i_state,
    input logic                     i_mem_read,
    input logic                     i_mem_write,
    input logic                     i_ir_write,
    input logic                     i_reg_write
);

    // single memory port
    a_no_read_and_write: assert property (
        @(posedge clk) disable iff (reset) !(i_mem_read && i_mem_write)
    ) else $error("mem_read and mem_write high in the same cycle");

    a_ir_write_in_fetch: assert property (
        @(posedge clk) disable iff (reset) i_ir_write |-> i_state == mc_ctrl_pkg::ST_FETCH
    ) else $error("ir_write high outside ST_FETCH");

    a_no_reg_write: assert property (
        @(posedge clk) disable iff (reset)
        i_state inside {mc_ctrl_pkg::ST_BRANCH, mc_ctrl_pkg::ST_STORE_WORD,
                        mc_ctrl_pkg::ST_BYTE_STORE} |-> !i_reg_write
    ) else $error("reg_write high in a branch or store state");

endmodule

bind mc_control_unit mc_control_unit_assert mc_control_unit_assert_i (
    .clk         (clk),
    .reset       (reset),
    .i_state     (o_state),
    .i_mem_read  (o_mem_read),
    .i_mem_write (o_mem_write),
    .i_ir_write  (o_ir_write),
    .i_reg_write (o_reg_write)
);

/* tb/tb_mc_control_unit.sv */
`timescale 1ns/100ps

module tb_mc_control_unit;

    logic                     clk;
    logic                     reset;
    mc_ctrl_pkg::opcode_e     i_opcode;
    mc_ctrl_pkg::funct_e      i_funct;
    logic                     i_eq;
    mc_ctrl_pkg::ctrl_state_e o_state;
    logic                     o_pc_write;
    logic                     o_mem_read;
    logic                     o_mem_write;
    logic                     o_byte_or_word;
    logic                     o_addr_from_alu;
    logic                     o_ir_write;
    logic                     o_reg_write;
    mc_ctrl_pkg::alu_op_e     o_alu_op;
    mc_ctrl_pkg::alu_src_a_e  o_alu_src_a;
    mc_ctrl_pkg::alu_src_b_e  o_alu_src_b;
    mc_ctrl_pkg::sh_op_e      o_sh_op;
    mc_ctrl_pkg::wb_src_e     o_wb_src;
    mc_ctrl_pkg::pc_src_e     o_pc_src;
    mc_ctrl_pkg::reg_dst_e    o_reg_dst;

    integer seed;
    int     rnd;
    int     errors;
    int     errors_before; // errors at the start of the running test
    int     tests;
    int     cycles; // clocks since the last fetch

    mc_control_unit mc_control_unit_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task report_value(input string name, input string got, input string exp);
        $display("FAILED at %0t ns: %s is %s, expected %s", $time, name, got, exp);
        errors++;
    endtask

    task compare_state(input mc_ctrl_pkg::ctrl_state_e exp);
        if (o_state !== exp) report_value("o_state", o_state.name(), exp.name());
    endtask

    task compare_alu_op(input mc_ctrl_pkg::alu_op_e exp);
        if (o_alu_op !== exp) report_value("o_alu_op", o_alu_op.name(), exp.name());
    endtask

    task compare_wb_src(input mc_ctrl_pkg::wb_src_e exp);
        if (o_wb_src !== exp) report_value("o_wb_src", o_wb_src.name(), exp.name());
    endtask

    task compare_pc_src(input mc_ctrl_pkg::pc_src_e exp);
        if (o_pc_src !== exp) report_value("o_pc_src", o_pc_src.name(), exp.name());
    endtask

    task compare_sh_op(input mc_ctrl_pkg::sh_op_e exp);
        if (o_sh_op !== exp) report_value("o_sh_op", o_sh_op.name(), exp.name());
    endtask

    task compare_reg_dst(input mc_ctrl_pkg::reg_dst_e exp);
        if (o_reg_dst !== exp) report_value("o_reg_dst", o_reg_dst.name(), exp.name());
    endtask

    task compare_src_a(input mc_ctrl_pkg::alu_src_a_e exp);
        if (o_alu_src_a !== exp) report_value("o_alu_src_a", o_alu_src_a.name(), exp.name());
    endtask

    task compare_src_b(input mc_ctrl_pkg::alu_src_b_e exp);
        if (o_alu_src_b !== exp) report_value("o_alu_src_b", o_alu_src_b.name(), exp.name());
    endtask

    task compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) report_value(name, $sformatf("%b", got), $sformatf("%b", exp));
    endtask

    task compare_count(input int got, input int exp);
        if (got != exp) report_value("fetch to fetch cycles", $sformatf("%0d", got),
                                     $sformatf("%0d", exp));
    endtask

    task check_enables(input logic pcw, input logic mr, input logic mw, input logic irw,
                       input logic rw);
        compare_bit("o_pc_write", o_pc_write, pcw);
        compare_bit("o_mem_read", o_mem_read, mr);
        compare_bit("o_mem_write", o_mem_write, mw);
        compare_bit("o_ir_write", o_ir_write, irw);
        compare_bit("o_reg_write", o_reg_write, rw);
    endtask

    task tick();
        @(posedge clk);
        #2; // outputs settled and inputs free to change
        cycles++;
    endtask

    // walks the common front from ST_FETCH up to decode
    task start_instr(input mc_ctrl_pkg::opcode_e op, input mc_ctrl_pkg::funct_e fn);
        i_opcode = op;
        i_funct = fn;
        cycles = 0;
        errors_before = errors;
        tick();
        compare_state(mc_ctrl_pkg::ST_TARGET);
        check_enables(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        tick();
        compare_state(mc_ctrl_pkg::ST_DECODE);
        check_enables(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    task end_instr(input int exp_cycles, input string name);
        int guard;
        guard = 0;
        while (o_state !== mc_ctrl_pkg::ST_FETCH && guard < 10) begin
            tick();
            guard++;
        end
        if (o_state !== mc_ctrl_pkg::ST_FETCH) begin
            $display("%s: state did not return to ST_FETCH within 10 cycles", name);
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            compare_count(cycles, exp_cycles);
            tests++;
            $display("%s done, %0d errors", name, errors - errors_before);
        end
    endtask

    task reset_sequence();
        errors_before = errors;
        repeat (3) begin
            tick();
            compare_state(mc_ctrl_pkg::ST_RESET);
            check_enables(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        end
        reset = 1'b0;
        compare_state(mc_ctrl_pkg::ST_RESET); // one idle cycle after reset
        check_enables(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        tick();
        compare_state(mc_ctrl_pkg::ST_FETCH);
        check_enables(1'b1, 1'b1, 1'b0, 1'b1, 1'b0);
        compare_alu_op(mc_ctrl_pkg::ALU_ADD);
        compare_src_a(mc_ctrl_pkg::SRC_A_PC);
        compare_src_b(mc_ctrl_pkg::SRC_B_FOUR);
        tests++;
        $display("reset done, %0d errors", errors - errors_before);
    endtask

    task alu_rtype(input mc_ctrl_pkg::funct_e fn, input mc_ctrl_pkg::alu_op_e op,
                   input string name);
        start_instr(mc_ctrl_pkg::OP_RTYPE, fn);
        tick();
        compare_state(mc_ctrl_pkg::ST_ALU_EXEC);
        compare_alu_op(op);
        compare_src_a(mc_ctrl_pkg::SRC_A_REG);
        compare_src_b(mc_ctrl_pkg::SRC_B_REG);
        tick();
        compare_state(mc_ctrl_pkg::ST_ALU_WB);
        check_enables(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        compare_wb_src(mc_ctrl_pkg::WB_ALU);
        compare_reg_dst(mc_ctrl_pkg::DST_RD);
        end_instr(5, name);
    endtask

    task set_less_than();
        start_instr(mc_ctrl_pkg::OP_RTYPE, mc_ctrl_pkg::FN_SLT);
        tick();
        compare_state(mc_ctrl_pkg::ST_SLT);
        check_enables(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        compare_wb_src(mc_ctrl_pkg::WB_SLT);
        compare_reg_dst(mc_ctrl_pkg::DST_RD);
        end_instr(4, "slt");
    endtask

    task shift_rtype(input mc_ctrl_pkg::funct_e fn, input mc_ctrl_pkg::sh_op_e sh,
                     input string name);
        start_instr(mc_ctrl_pkg::OP_RTYPE, fn);
        tick();
        compare_state(mc_ctrl_pkg::ST_SHIFT_EXEC);
        compare_sh_op(sh);
        tick();
        compare_state(mc_ctrl_pkg::ST_SHIFT_WB);
        check_enables(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        compare_wb_src(mc_ctrl_pkg::WB_SHIFT);
        end_instr(5, name);
    endtask

    task add_immediate();
        start_instr(mc_ctrl_pkg::OP_ADDI, mc_ctrl_pkg::FN_ADD);
        tick();
        compare_state(mc_ctrl_pkg::ST_IMM_EXEC);
        compare_src_b(mc_ctrl_pkg::SRC_B_IMM);
        tick();
        compare_state(mc_ctrl_pkg::ST_IMM_WB);
        check_enables(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        compare_reg_dst(mc_ctrl_pkg::DST_RT);
        end_instr(5, "addi");
    endtask

    task load_upper();
        start_instr(mc_ctrl_pkg::OP_LUI, mc_ctrl_pkg::FN_ADD);
        tick();
        compare_state(mc_ctrl_pkg::ST_LUI_WB);
        check_enables(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        compare_wb_src(mc_ctrl_pkg::WB_UPPER);
        end_instr(4, "lui");
    endtask

    task branch_cond(input mc_ctrl_pkg::opcode_e op, input string name);
        rnd = $random(seed);
        i_eq = rnd[0]; // only looked at in ST_BRANCH
        start_instr(op, mc_ctrl_pkg::FN_ADD);
        tick();
        compare_state(mc_ctrl_pkg::ST_BRANCH);
        compare_pc_src(mc_ctrl_pkg::PC_TARGET);
        compare_bit("o_pc_write", o_pc_write, (op == mc_ctrl_pkg::OP_BEQ) ? i_eq : ~i_eq);
        compare_bit("o_reg_write", o_reg_write, 1'b0);
        end_instr(4, name);
    endtask

    task jump_path(input mc_ctrl_pkg::opcode_e op, input mc_ctrl_pkg::funct_e fn,
                   input mc_ctrl_pkg::ctrl_state_e st, input mc_ctrl_pkg::pc_src_e src,
                   input string name);
        start_instr(op, fn);
        tick();
        compare_state(st);
        check_enables(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        compare_pc_src(src);
        end_instr(4, name);
    endtask

    task load_path(input mc_ctrl_pkg::opcode_e op, input mc_ctrl_pkg::wb_src_e wb,
                   input string name);
        start_instr(op, mc_ctrl_pkg::FN_ADD);
        tick();
        compare_state(mc_ctrl_pkg::ST_ADDR_CALC);
        compare_src_b(mc_ctrl_pkg::SRC_B_IMM);
        tick();
        compare_state(mc_ctrl_pkg::ST_LOAD_READ);
        check_enables(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        compare_bit("o_addr_from_alu", o_addr_from_alu, 1'b1);
        tick();
        compare_state(mc_ctrl_pkg::ST_LOAD_WB);
        check_enables(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        compare_wb_src(wb);
        end_instr(6, name);
    endtask

    task store_word();
        start_instr(mc_ctrl_pkg::OP_SW, mc_ctrl_pkg::FN_ADD);
        tick();
        compare_state(mc_ctrl_pkg::ST_ADDR_CALC);
        tick();
        compare_state(mc_ctrl_pkg::ST_STORE_WORD);
        check_enables(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        compare_bit("o_addr_from_alu", o_addr_from_alu, 1'b1);
        compare_bit("o_byte_or_word", o_byte_or_word, 1'b0);
        end_instr(5, "sw");
    endtask

    task store_byte();
        start_instr(mc_ctrl_pkg::OP_SB, mc_ctrl_pkg::FN_ADD);
        tick();
        compare_state(mc_ctrl_pkg::ST_ADDR_CALC);
        tick();
        compare_state(mc_ctrl_pkg::ST_BYTE_READ); // read, modify, write
        check_enables(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        tick();
        compare_state(mc_ctrl_pkg::ST_BYTE_STORE);
        check_enables(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        compare_bit("o_byte_or_word", o_byte_or_word, 1'b1);
        end_instr(6, "sb");
    endtask

    task unknown_instr(input mc_ctrl_pkg::opcode_e op, input mc_ctrl_pkg::funct_e fn,
                       input string name);
        start_instr(op, fn); // enables already checked idle up to decode
        end_instr(3, name);
    endtask

    initial begin
        seed = 32'hb82d85b4;
        errors = 0;
        errors_before = 0;
        tests = 0;
        cycles = 0;
        rnd = 0;
        reset = 1'b1;
        i_opcode = mc_ctrl_pkg::OP_RTYPE;
        i_funct = mc_ctrl_pkg::FN_ADD;
        i_eq = 1'b0;

        reset_sequence();
        alu_rtype(mc_ctrl_pkg::FN_ADD, mc_ctrl_pkg::ALU_ADD, "add");
        alu_rtype(mc_ctrl_pkg::FN_AND, mc_ctrl_pkg::ALU_AND, "and");
        alu_rtype(mc_ctrl_pkg::FN_SUB, mc_ctrl_pkg::ALU_SUB, "sub");
        set_less_than();
        shift_rtype(mc_ctrl_pkg::FN_SLL, mc_ctrl_pkg::SH_SLL, "sll");
        shift_rtype(mc_ctrl_pkg::FN_SRA, mc_ctrl_pkg::SH_SRA, "sra");
        add_immediate();
        load_upper();
        repeat (4) begin
            branch_cond(mc_ctrl_pkg::OP_BEQ, "beq");
            branch_cond(mc_ctrl_pkg::OP_BNE, "bne");
        end
        jump_path(mc_ctrl_pkg::OP_J, mc_ctrl_pkg::FN_ADD, mc_ctrl_pkg::ST_JUMP,
                  mc_ctrl_pkg::PC_JUMP, "j");
        jump_path(mc_ctrl_pkg::OP_RTYPE, mc_ctrl_pkg::FN_JR, mc_ctrl_pkg::ST_JUMP_REG,
                  mc_ctrl_pkg::PC_REG, "jr");
        load_path(mc_ctrl_pkg::OP_LW, mc_ctrl_pkg::WB_WORD, "lw");
        load_path(mc_ctrl_pkg::OP_LB, mc_ctrl_pkg::WB_BYTE, "lb");
        store_word();
        store_byte();
        unknown_instr(mc_ctrl_pkg::opcode_e'(6'h3f), mc_ctrl_pkg::FN_ADD, "unknown opcode");
        unknown_instr(mc_ctrl_pkg::OP_RTYPE, mc_ctrl_pkg::funct_e'(6'h01), "unknown funct");

        $display("%0d tests run, %0d checks failed", tests, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+verilog
verilog/mc_ctrl_pkg.sv
verilog/ctrl_word_if.sv
verilog/instr_decoder.sv
verilog/ctrl_sequencer.sv
verilog/ctrl_word_gen.sv
verilog/mc_control_unit.sv
tb/mc_control_unit_assert.sv
tb/tb_mc_control_unit.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -f vlog.f \
		--top-module tb_mc_control_unit -o Vtb_mc_control_unit
	./obj_dir/Vtb_mc_control_unit > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
